// ==== design/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// integer register and datapath width
`define CORE_XLEN 64

// pc and fetch address width
// upper half of a 64 bit address is never used here
`define CORE_PC_W 32

// first fetch address after reset
`define CORE_RESET_PC 32'h8000_0000

// register index width
// 5 bits gives the 32 architectural registers
`define CORE_REG_ADDR_W 5

`endif

// ==== design/core_pkg.sv ====
package core_pkg;

  // operation passed from decode to execute
  // kept 8 bits wide so more ops can be added later
  typedef enum logic [7:0] {
    // no register write
    op_none = 8'h00,
    // op1 + op2 into rd
    op_add  = 8'h01
  } exu_op_e;

  // instruction format class seen by decode
  typedef enum logic [1:0] {
    // dummy, ebreak, invalid
    cls_none = 2'd0,
    // addi, jalr
    cls_i    = 2'd1,
    // lui, auipc
    cls_u    = 2'd2,
    // jal
    cls_j    = 2'd3
  } inst_class_e;

  // fetch fsm states
  typedef enum logic [1:0] {
    // req high, waiting for ack
    st_req      = 2'd0,
    // req low, waiting for ack to drop
    st_wait_low = 2'd1,
    // one cycle of decode, execute and commit
    st_exec     = 2'd2,
    // stopped until reset
    st_halt     = 2'd3
  } fetch_state_e;

endpackage

// ==== design/core_ifu.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_ifu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_ack,
  input  logic [31:0]           inst_data,
  input  logic                  jump_flag,
  input  logic [`CORE_PC_W-1:0] jump_target,
  input  logic                  inst_ebreak,
  input  logic                  invalid_inst,
  output logic                  inst_req,
  output logic [`CORE_PC_W-1:0] inst_addr,
  output logic [`CORE_PC_W-1:0] pc,
  output logic [31:0]           inst,
  output logic                  exec,
  output logic                  halted,
  output logic                  invalid_seen
);
  import core_pkg::*;

  // sequential fetch step
  localparam logic [`CORE_PC_W-1:0] pc_step = 4;

  fetch_state_e state;
  fetch_state_e state_nxt;
  logic         stop;
  logic         take_inst;

  // ebreak or a bad word ends the run
  assign stop = inst_ebreak | invalid_inst;

  // ack only counts while our own req is up
  assign take_inst = (state == st_req) & inst_req & inst_ack;

  // four phase handshake sequencing
  always_comb begin
    state_nxt = state;
    case (state)
      st_req: begin
        if (take_inst) begin
          state_nxt = st_wait_low;
        end
      end
      st_wait_low: begin
        // ack must be seen low before the next req
        if (!inst_ack) begin
          state_nxt = st_exec;
        end
      end
      st_exec: begin
        state_nxt = stop ? st_halt : st_req;
      end
      st_halt: begin
        state_nxt = st_halt;
      end
      default: begin
        state_nxt = st_req;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_req;
      inst_req     <= 1'b0;
      pc           <= `CORE_RESET_PC;
      invalid_seen <= 1'b0;
    end else begin
      state    <= state_nxt;
      // registered req, low during reset, up one cycle after release
      inst_req <= (state_nxt == st_req);
      if (state == st_exec) begin
        // next pc chosen at the end of exec
        pc <= jump_flag ? jump_target : pc + pc_step;
        // sticky until reset
        if (invalid_inst) begin
          invalid_seen <= 1'b1;
        end
      end
    end
  end

  // instruction latch, loaded on the ack cycle
  always_ff @(posedge clk) begin
    if (take_inst) begin
      inst <= inst_data;
    end
  end

  // address held at pc for the whole request
  assign inst_addr = pc;
  assign exec      = (state == st_exec);
  assign halted    = (state == st_halt);

endmodule

// ==== design/core_idu.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_idu (
  input  logic [`CORE_PC_W-1:0]       pc,
  input  logic [31:0]                 inst,
  input  logic [`CORE_XLEN-1:0]       rs1_data,
  output core_pkg::exu_op_e           exu_op,
  output logic [`CORE_XLEN-1:0]       op1,
  output logic [`CORE_XLEN-1:0]       op2,
  output logic [`CORE_PC_W-1:0]       op1_jump,
  output logic [`CORE_PC_W-1:0]       op2_jump,
  output logic                        jump_flag,
  output logic                        inst_ebreak,
  output logic                        invalid_inst,
  output logic                        rs1_r_en,
  output logic [`CORE_REG_ADDR_W-1:0] rs1_r_addr,
  output logic                        rd_w_en,
  output logic [`CORE_REG_ADDR_W-1:0] rd_w_addr
);
  import core_pkg::*;

  // major opcodes of the supported subset
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_system = 7'b1110011;

  logic [6:0]                  opcode;
  logic [2:0]                  func3;
  logic [`CORE_REG_ADDR_W-1:0] rd;
  logic [`CORE_REG_ADDR_W-1:0] rs1;
  logic [`CORE_XLEN-1:0]       src_i;
  logic [`CORE_XLEN-1:0]       src_u;
  logic [`CORE_PC_W-1:0]       src_j;
  logic [`CORE_XLEN-1:0]       pc_ext;
  logic                        inst_dummy;
  logic                        inst_addi;
  logic                        inst_lui;
  logic                        inst_auipc;
  logic                        inst_jal;
  logic                        inst_jalr;
  inst_class_e                 inst_class;

  // fixed instruction fields
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign func3  = inst[14:12];
  assign rs1    = inst[19:15];

  // sign extended immediates
  assign src_i = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
  assign src_u = {{(`CORE_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  // j immediate is scrambled in the word, bit 0 always zero
  assign src_j = {{(`CORE_PC_W-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // pc zero extended to data width
  assign pc_ext = {{(`CORE_XLEN-`CORE_PC_W){1'b0}}, pc};

  // all zero word behaves as a nop
  assign inst_dummy  = (inst == 32'h0);
  assign inst_addi   = (opcode == opc_imm) && (func3 == 3'b000);
  assign inst_lui    = (opcode == opc_lui);
  assign inst_auipc  = (opcode == opc_auipc);
  assign inst_jal    = (opcode == opc_jal);
  assign inst_jalr   = (opcode == opc_jalr) && (func3 == 3'b000);
  // only func3 is checked for ebreak, imm field ignored
  assign inst_ebreak = (opcode == opc_system) && (func3 == 3'b000);

  // anything outside the subset
  assign invalid_inst = ~(inst_dummy | inst_addi | inst_ebreak | inst_lui |
                          inst_auipc | inst_jal | inst_jalr);

  assign jump_flag = inst_jal | inst_jalr;

  // format class drives operand muxing
  always_comb begin
    inst_class = cls_none;
    if (inst_addi || inst_jalr) begin
      inst_class = cls_i;
    end else if (inst_lui || inst_auipc) begin
      inst_class = cls_u;
    end else if (inst_jal) begin
      inst_class = cls_j;
    end
  end

  // rs1 read only for i format
  assign rs1_r_en   = (inst_class == cls_i);
  assign rs1_r_addr = rs1_r_en ? rs1 : '0;

  // every recognized non-system op writes rd
  assign rd_w_en   = (inst_class != cls_none);
  assign rd_w_addr = rd_w_en ? rd : '0;
  assign exu_op    = rd_w_en ? op_add : op_none;

  // operand selection
  always_comb begin
    op1      = '0;
    op2      = '0;
    op1_jump = '0;
    op2_jump = '0;
    case (inst_class)
      cls_i: begin
        if (inst_jalr) begin
          // link value pc + 4, target rs1 + imm
          op1      = pc_ext;
          op2      = 64'd4;
          op1_jump = rs1_data[`CORE_PC_W-1:0];
          op2_jump = src_i[`CORE_PC_W-1:0];
        end else begin
          op1 = rs1_data;
          op2 = src_i;
        end
      end
      cls_u: begin
        // lui adds to zero, auipc to pc
        op1 = inst_auipc ? pc_ext : '0;
        op2 = src_u;
      end
      cls_j: begin
        op1      = pc_ext;
        op2      = 64'd4;
        op1_jump = pc;
        op2_jump = src_j;
      end
      default: begin
        // nothing to compute
        op1 = '0;
        op2 = '0;
      end
    endcase
  end

endmodule

// ==== design/core_regfile.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_regfile (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`CORE_REG_ADDR_W-1:0] r_addr,
  input  logic                        w_en,
  input  logic [`CORE_REG_ADDR_W-1:0] w_addr,
  input  logic [`CORE_XLEN-1:0]       w_data,
  output logic [`CORE_XLEN-1:0]       r_data
);

  // one entry per index value
  localparam int reg_num = 1 << `CORE_REG_ADDR_W;

  logic [`CORE_XLEN-1:0] regs [reg_num];

  // synchronous write, x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_num; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en && (w_addr != '0)) begin
      regs[w_addr] <= w_data;
    end
  end

  // combinational read
  // x0 forced to zero on the read side as well
  assign r_data = (r_addr == '0) ? '0 : regs[r_addr];

endmodule

// ==== design/core_exu.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_exu (
  input  logic                        exec,
  input  logic [`CORE_PC_W-1:0]       pc,
  input  core_pkg::exu_op_e           exu_op,
  input  logic [`CORE_XLEN-1:0]       op1,
  input  logic [`CORE_XLEN-1:0]       op2,
  input  logic [`CORE_PC_W-1:0]       op1_jump,
  input  logic [`CORE_PC_W-1:0]       op2_jump,
  input  logic                        rd_w_en,
  input  logic [`CORE_REG_ADDR_W-1:0] rd_w_addr,
  output logic [`CORE_PC_W-1:0]       jump_target,
  output logic                        wb_en,
  output logic [`CORE_REG_ADDR_W-1:0] wb_addr,
  output logic [`CORE_XLEN-1:0]       wb_data,
  output logic                        commit_valid,
  output logic [`CORE_PC_W-1:0]       commit_pc,
  output logic                        commit_rd_en,
  output logic [`CORE_REG_ADDR_W-1:0] commit_rd_addr,
  output logic [`CORE_XLEN-1:0]       commit_rd_data
);
  import core_pkg::*;

  logic [`CORE_XLEN-1:0] result;
  logic [`CORE_PC_W-1:0] jump_sum;

  // main adder
  assign result = (exu_op == op_add) ? op1 + op2 : '0;

  // jump adder
  assign jump_sum = op1_jump + op2_jump;
  // bit 0 cleared as jalr needs
  // jal sums are even already so this is harmless there
  assign jump_target = {jump_sum[`CORE_PC_W-1:1], 1'b0};

  // write back only in the exec cycle
  assign wb_en   = exec & rd_w_en & (exu_op == op_add);
  assign wb_addr = wb_en ? rd_w_addr : '0;
  assign wb_data = wb_en ? result : '0;

  // commit mirrors the write back
  assign commit_valid   = exec;
  assign commit_pc      = exec ? pc : '0;
  assign commit_rd_en   = wb_en;
  assign commit_rd_addr = wb_addr;
  assign commit_rd_data = wb_data;

endmodule

// ==== design/core_top.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top (
  input  logic                        clk,
  input  logic                        rst,
  output logic                        inst_req,
  output logic [`CORE_PC_W-1:0]       inst_addr,
  input  logic                        inst_ack,
  input  logic [31:0]                 inst_data,
  output logic                        commit_valid,
  output logic [`CORE_PC_W-1:0]       commit_pc,
  output logic                        commit_rd_en,
  output logic [`CORE_REG_ADDR_W-1:0] commit_rd_addr,
  output logic [`CORE_XLEN-1:0]       commit_rd_data,
  output logic                        halted,
  output logic                        invalid_inst
);
  import core_pkg::*;

  // fetch to decode
  logic [`CORE_PC_W-1:0]       pc;
  logic [31:0]                 inst;
  logic                        exec;
  // decode outputs
  exu_op_e                     exu_op;
  logic [`CORE_XLEN-1:0]       op1;
  logic [`CORE_XLEN-1:0]       op2;
  logic [`CORE_PC_W-1:0]       op1_jump;
  logic [`CORE_PC_W-1:0]       op2_jump;
  logic                        jump_flag;
  logic                        inst_ebreak;
  logic                        invalid_dec;
  logic [`CORE_REG_ADDR_W-1:0] rs1_r_addr;
  logic [`CORE_XLEN-1:0]       rs1_data;
  logic                        rd_w_en;
  logic [`CORE_REG_ADDR_W-1:0] rd_w_addr;
  // execute back to fetch and regfile
  logic [`CORE_PC_W-1:0]       jump_target;
  logic                        wb_en;
  logic [`CORE_REG_ADDR_W-1:0] wb_addr;
  logic [`CORE_XLEN-1:0]       wb_data;

  core_ifu i_core_ifu (
    .clk          (clk),
    .rst          (rst),
    .inst_ack     (inst_ack),
    .inst_data    (inst_data),
    .jump_flag    (jump_flag),
    .jump_target  (jump_target),
    .inst_ebreak  (inst_ebreak),
    .invalid_inst (invalid_dec),
    .inst_req     (inst_req),
    .inst_addr    (inst_addr),
    .pc           (pc),
    .inst         (inst),
    .exec         (exec),
    .halted       (halted),
    .invalid_seen (invalid_inst)
  );

  // rs1_r_en only gates the read address inside decode
  core_idu i_core_idu (
    .pc           (pc),
    .inst         (inst),
    .rs1_data     (rs1_data),
    .exu_op       (exu_op),
    .op1          (op1),
    .op2          (op2),
    .op1_jump     (op1_jump),
    .op2_jump     (op2_jump),
    .jump_flag    (jump_flag),
    .inst_ebreak  (inst_ebreak),
    .invalid_inst (invalid_dec),
    .rs1_r_en     (),
    .rs1_r_addr   (rs1_r_addr),
    .rd_w_en      (rd_w_en),
    .rd_w_addr    (rd_w_addr)
  );

  core_regfile i_core_regfile (
    .clk    (clk),
    .rst    (rst),
    .r_addr (rs1_r_addr),
    .w_en   (wb_en),
    .w_addr (wb_addr),
    .w_data (wb_data),
    .r_data (rs1_data)
  );

  core_exu i_core_exu (
    .exec           (exec),
    .pc             (pc),
    .exu_op         (exu_op),
    .op1            (op1),
    .op2            (op2),
    .op1_jump       (op1_jump),
    .op2_jump       (op2_jump),
    .rd_w_en        (rd_w_en),
    .rd_w_addr      (rd_w_addr),
    .jump_target    (jump_target),
    .wb_en          (wb_en),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_rd_en   (commit_rd_en),
    .commit_rd_addr (commit_rd_addr),
    .commit_rd_data (commit_rd_data)
  );

endmodule

// ==== tb/core_assertions.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   inst_req,
  input logic                   inst_ack,
  input logic [`CORE_PC_W-1:0]  inst_addr,
  input logic                   exec
);

  int fail_count = 0;

  // address held for the whole request
  addr_stable: assert property (@(posedge clk) disable iff (rst)
    (inst_req && $past(inst_req)) |-> $stable(inst_addr))
    else begin
      fail_count = fail_count + 1;
      $error("inst_addr changed while inst_req was high");
    end

  // ack must fall before a new req
  req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
    (inst_ack && !inst_req) |=> !inst_req)
    else begin
      fail_count = fail_count + 1;
      $error("inst_req rose while inst_ack was still high");
    end

  // exec for one cycle right after ack falls
  exec_one_cycle: assert property (@(posedge clk) disable iff (rst)
    $fell(inst_ack) |=> exec ##1 !exec)
    else begin
      fail_count = fail_count + 1;
      $error("exec did not last exactly one cycle after inst_ack fell");
    end

endmodule

bind core_ifu core_assertions i_core_assertions (
  .clk       (clk),
  .rst       (rst),
  .inst_req  (inst_req),
  .inst_ack  (inst_ack),
  .inst_addr (inst_addr),
  .exec      (exec)
);

// ==== tb/core_tb.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;

  localparam int clk_period  = 8;
  localparam int mem_depth   = 64;
  // commits summed over all five tests
  localparam int total_insts = 34;
  localparam int ebreak_word = 32'h0010_0073;

  logic                        clk;
  logic                        rst;
  logic                        inst_req;
  logic [`CORE_PC_W-1:0]       inst_addr;
  logic                        inst_ack  = 1'b0;
  logic [31:0]                 inst_data = 32'h0;
  logic                        commit_valid;
  logic [`CORE_PC_W-1:0]       commit_pc;
  logic                        commit_rd_en;
  logic [4:0]                  commit_rd_addr;
  logic [`CORE_XLEN-1:0]       commit_rd_data;
  logic                        halted;
  logic                        invalid_inst;

  // instruction memory and its answer delay
  logic [31:0] imem [mem_depth];
  logic [1:0]  wait_cnt = 2'd0;
  integer      seed     = 32'ha0cb_7ffd;

  // reference model state
  logic [63:0] m_regs [32];
  logic [31:0] m_pc;
  logic        m_halted;
  logic        m_invalid;
  int          n_commits;

  core_top i_core_top (
    .clk            (clk),
    .rst            (rst),
    .inst_req       (inst_req),
    .inst_addr      (inst_addr),
    .inst_ack       (inst_ack),
    .inst_data      (inst_data),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_rd_en   (commit_rd_en),
    .commit_rd_addr (commit_rd_addr),
    .commit_rd_data (commit_rd_data),
    .halted         (halted),
    .invalid_inst   (invalid_inst)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      stop_with_error("value check failed");
    end
  endtask

  function automatic int mem_index(input logic [31:0] addr);
    return int'((addr - `CORE_RESET_PC) >> 2) & (mem_depth - 1);
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_jalr(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
  endfunction

  // unused words decode as invalid and differ from each other
  task automatic clear_mem();
    for (int i = 0; i < mem_depth; i++) begin
      imem[i] = {i[24:0], 7'h7f};
    end
  endtask

  // memory answers each request after 0 to 3 cycles
  always @(posedge clk) begin
    if (rst) begin
      inst_ack <= 1'b0;
      wait_cnt <= 2'($random(seed));
    end else if (inst_req && !inst_ack) begin
      if (wait_cnt == 2'd0) begin
        // fetch address must be the pc the model expects next
        check_value("inst_addr", 64'(inst_addr), 64'(m_pc));
        inst_ack  <= 1'b1;
        inst_data <= imem[mem_index(inst_addr)];
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else if (!inst_req) begin
      // release ack and pick the next delay once req is gone
      inst_ack <= 1'b0;
      wait_cnt <= 2'($random(seed));
    end
  end

  task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = 64'h0;
    end
    m_pc      = `CORE_RESET_PC;
    m_halted  = 1'b0;
    m_invalid = 1'b0;
    n_commits = 0;
  endtask

  // one retired instruction of the model compared with the commit port
  task automatic model_commit();
    logic [31:0] w;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [31:0] imm_j;
    logic [63:0] pc64;
    logic        wen;
    logic [63:0] val;
    logic [31:0] npc;
    if (m_halted) begin
      stop_with_error("the core committed an instruction after it should have halted");
    end
    w     = imem[mem_index(m_pc)];
    opc   = w[6:0];
    f3    = w[14:12];
    rd    = w[11:7];
    rs1   = w[19:15];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_u = {{32{w[31]}}, w[31:12], 12'h0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    // pc is an unsigned 32 bit address
    pc64  = {32'h0, m_pc};
    wen   = 1'b0;
    val   = 64'h0;
    npc   = m_pc + 32'd4;
    if (w == 32'h0) begin
      // dummy word writes nothing
      wen = 1'b0;
    end else if (opc == 7'h13 && f3 == 3'd0) begin
      wen = 1'b1;
      val = m_regs[rs1] + imm_i;
    end else if (opc == 7'h37) begin
      wen = 1'b1;
      val = imm_u;
    end else if (opc == 7'h17) begin
      wen = 1'b1;
      val = pc64 + imm_u;
    end else if (opc == 7'h6f) begin
      wen = 1'b1;
      val = pc64 + 64'd4;
      npc = m_pc + imm_j;
    end else if (opc == 7'h67 && f3 == 3'd0) begin
      wen = 1'b1;
      val = pc64 + 64'd4;
      // rs1 read before rd is written
      npc = (m_regs[rs1][31:0] + imm_i[31:0]) & 32'hffff_fffe;
    end else if (opc == 7'h73 && f3 == 3'd0) begin
      m_halted = 1'b1;
    end else begin
      m_halted  = 1'b1;
      m_invalid = 1'b1;
    end
    check_value("commit_pc", 64'(commit_pc), 64'(m_pc));
    check_value("commit_rd_en", 64'(commit_rd_en), 64'(wen));
    check_value("commit_rd_addr", 64'(commit_rd_addr), wen ? 64'(rd) : 64'h0);
    check_value("commit_rd_data", commit_rd_data, val);
    // x0 stays zero in the model
    if (wen && rd != 5'd0) begin
      m_regs[rd] = val;
    end
    m_pc      = npc;
    n_commits = n_commits + 1;
  endtask

  // commit port sampled mid cycle
  always @(negedge clk) begin
    if (!rst && commit_valid) begin
      model_commit();
    end
  end

  // reset, run until halted, then check the end state
  task automatic run_program(input int exp_count, input logic exp_invalid);
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_value("inst_req", 64'(inst_req), 64'h0);
    check_value("commit_valid", 64'(commit_valid), 64'h0);
    check_value("halted", 64'(halted), 64'h0);
    check_value("invalid_inst", 64'(invalid_inst), 64'h0);
    @(posedge clk);
    model_reset();
    rst <= 1'b0;
    @(negedge clk);
    while (!halted) begin
      @(negedge clk);
    end
    check_value("commit count", 64'(n_commits), 64'(exp_count));
    check_value("invalid_inst", 64'(invalid_inst), 64'(exp_invalid));
    check_value("model halted", 64'(m_halted), 64'h1);
  endtask

  task automatic test_addi_chain();
    clear_mem();
    imem[0] = enc_addi(1, 0, 5);
    imem[1] = enc_addi(2, 1, -3);
    imem[2] = enc_addi(3, 2, -2048);
    // write to x0 is dropped
    imem[3] = enc_addi(0, 1, 100);
    imem[4] = enc_addi(4, 0, 2047);
    imem[5] = enc_addi(5, 3, 1);
    imem[6] = ebreak_word;
    run_program(7, 1'b0);
  endtask

  task automatic test_lui_auipc();
    clear_mem();
    imem[0] = enc_u(7'h37, 6, 20'h12345);
    // upper bit set so the value sign extends
    imem[1] = enc_u(7'h37, 7, 20'hfffff);
    imem[2] = enc_u(7'h17, 8, 20'h00001);
    imem[3] = enc_u(7'h17, 9, 20'h80000);
    imem[4] = enc_addi(10, 7, 1);
    imem[5] = ebreak_word;
    run_program(6, 1'b0);
  endtask

  task automatic test_jumps();
    clear_mem();
    imem[0] = enc_jal(1, 12);
    imem[1] = enc_addi(2, 0, 1);
    imem[2] = enc_addi(2, 0, 2);
    imem[3] = enc_u(7'h17, 5, 0);
    // odd target lands on word 6 once bit 0 is cleared
    imem[4] = enc_jalr(6, 5, 13);
    imem[5] = ebreak_word;
    imem[6] = enc_jal(7, 8);
    imem[7] = enc_addi(2, 0, 3);
    // backward jump to word 5 with the link into x0
    imem[8] = enc_jal(0, -12);
    run_program(6, 1'b0);
  endtask

  task automatic test_dummy_delay();
    clear_mem();
    for (int i = 0; i < 10; i++) begin
      imem[i] = (i % 2 == 0) ? 32'h0 : enc_addi(1, 1, i);
    end
    imem[10] = ebreak_word;
    run_program(11, 1'b0);
  endtask

  task automatic test_halt();
    clear_mem();
    imem[0] = enc_addi(1, 0, 3);
    imem[1] = ebreak_word;
    imem[2] = enc_addi(2, 0, 4);
    run_program(2, 1'b0);
    repeat (50) @(negedge clk);
    check_value("commit count after halt", 64'(n_commits), 64'd2);
    check_value("halted", 64'(halted), 64'h1);
    clear_mem();
    imem[0] = enc_addi(1, 0, 9);
    // R type add is outside the subset
    imem[1] = 32'h0020_81b3;
    imem[2] = enc_addi(2, 0, 4);
    run_program(2, 1'b1);
    // both flags stay up until the next reset
    repeat (50) @(negedge clk);
    check_value("halted", 64'(halted), 64'h1);
    check_value("invalid_inst", 64'(invalid_inst), 64'h1);
  endtask

  // generous bound per instruction over the whole run
  initial begin
    #(total_insts * 200 * clk_period);
    stop_with_error("timeout, the core stopped committing instructions");
  end

  initial begin
    rst = 1'b1;
    test_addi_chain();
    test_lui_auipc();
    test_jumps();
    test_dummy_delay();
    test_halt();
    if (i_core_top.i_core_ifu.i_core_assertions.fail_count != 0) begin
      stop_with_error("fetch handshake assertions failed during the run");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/core_pkg.sv
design/core_ifu.sv
design/core_idu.sv
design/core_regfile.sv
design/core_exu.sv
design/core_top.sv
tb/core_assertions.sv
tb/core_tb.sv

// ==== Makefile ====
SIM = obj_dir/core_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f verilog.f -o core_sim

run: compile
	out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
